// File: design/mixer_pkg.sv
////////////////////
// audio mixer package
// sample width, sample and multiplier job types,
// saturation limits and the FSM state encodings
////////////////////

`default_nettype none

package mixer_pkg;

  localparam int AUDIO_WIDTH = 16;

  typedef logic signed [AUDIO_WIDTH-1:0] audio_t;

  // saturation limits of one sample
  localparam audio_t AUDIO_MAX = audio_t'(2**(AUDIO_WIDTH-1) - 1);
  localparam audio_t AUDIO_MIN = audio_t'(-(2**(AUDIO_WIDTH-1)));

  // one multiply job, operands in Q format
  typedef struct packed {
    audio_t multiplicand;
    audio_t multiplier;
  } mul_req_t;

  typedef struct packed {
    logic   overflow;  // product was clamped
    audio_t product;
  } mul_rsp_t;

  ////////////////////
  // state encodings
  ////////////////////

  typedef enum logic [2:0] {
    STRIP_IDLE,
    STRIP_GAIN_REQ,
    STRIP_GAIN_WAIT,
    STRIP_PAN_REQ,
    STRIP_PAN_WAIT,
    STRIP_DONE
  } strip_state_t;

  typedef enum logic [2:0] {
    BUS_IDLE,
    BUS_WAIT_STRIPS,
    BUS_SUM,
    BUS_OUT_REQ,
    BUS_OUT_WAIT,
    BUS_EMIT
  } bus_state_t;

endpackage

`default_nettype wire

// File: design/nq_multiplier.sv
////////////////////
// Q-format multiplier
// two stage signed multiply, scaled by Q_BITS and
// clamped to one sample, tag follows the data
////////////////////

`timescale 1ns/1ns
`default_nettype none

module nq_multiplier import mixer_pkg::*; #(
  parameter int Q_BITS   = 12,
  parameter int ID_WIDTH = 3
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 mul_valid,
  input  wire  mul_req_t      mul_req,
  input  wire  [ID_WIDTH-1:0] mul_tag,
  output logic                res_valid,
  output mul_rsp_t            res,
  output logic [ID_WIDTH-1:0] res_tag
);

  localparam int PROD_WIDTH = 2 * AUDIO_WIDTH;

  typedef logic signed [PROD_WIDTH-1:0] product_t;

  product_t            prod_r;   // full width product
  logic                valid_r;
  logic [ID_WIDTH-1:0] tag_r;
  product_t            scaled;
  logic                fits;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_r   <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      valid_r   <= mul_valid;
      res_valid <= valid_r;
    end
  end

  // stage 1
  always_ff @(posedge clk) begin
    prod_r <= product_t'($signed(mul_req.multiplicand)) *
              product_t'($signed(mul_req.multiplier));
    tag_r  <= mul_tag;
  end

  assign scaled = prod_r >>> Q_BITS;

  // in range when all bits above the sample are copies of its sign
  assign fits = (&scaled[PROD_WIDTH-1:AUDIO_WIDTH-1]) |
                ~(|scaled[PROD_WIDTH-1:AUDIO_WIDTH-1]);

  // stage 2
  always_ff @(posedge clk) begin
    res_tag      <= tag_r;
    res.overflow <= ~fits;
    if (fits) begin
      res.product <= scaled[AUDIO_WIDTH-1:0];
    end else begin
      res.product <= scaled[PROD_WIDTH-1] ? AUDIO_MIN : AUDIO_MAX;
    end
  end

endmodule

`default_nettype wire

// File: design/mul_arbiter.sv
////////////////////
// multiplier arbiter
// round-robin pick of one request per cycle,
// products routed back to their owner by tag
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mul_arbiter import mixer_pkg::*; #(
  parameter  int NR_OF_CHANNELS = 4,
  parameter  int ID_WIDTH       = 3,
  localparam int NR_OF_REQ      = NR_OF_CHANNELS + 1
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire  [NR_OF_REQ-1:0]          req_valid,
  input  wire  mul_req_t [NR_OF_REQ-1:0] req,
  output logic [NR_OF_REQ-1:0]          req_grant,
  output logic                          mul_valid,
  output mul_req_t                      mul_req,
  output logic [ID_WIDTH-1:0]           mul_tag,
  input  wire                           res_valid,
  input  wire  mul_rsp_t                res,
  input  wire  [ID_WIDTH-1:0]           res_tag,
  output logic [NR_OF_REQ-1:0]          rsp_valid,
  output mul_rsp_t                      rsp
);

  logic [ID_WIDTH-1:0] prio_ptr;  // highest priority this cycle
  logic [ID_WIDTH-1:0] sel;

  ////////////////////
  // request side
  ////////////////////

  // first pending requester at or after the pointer
  always_comb begin
    int   idx;
    logic found;
    found = 1'b0;
    sel   = prio_ptr;
    for (int k = 0; k < NR_OF_REQ; k++) begin
      idx = int'(prio_ptr) + k;
      if (idx >= NR_OF_REQ) begin
        idx = idx - NR_OF_REQ;
      end
      if (!found && req_valid[idx]) begin
        found = 1'b1;
        sel   = ID_WIDTH'(idx);
      end
    end
  end

  assign mul_valid = |req_valid;
  assign mul_req   = req[sel];
  assign mul_tag   = sel;

  always_comb begin
    req_grant      = '0;
    req_grant[sel] = mul_valid;
  end

  // winner drops to lowest priority
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prio_ptr <= '0;
    end else if (mul_valid) begin
      prio_ptr <= (sel == ID_WIDTH'(NR_OF_REQ - 1)) ? '0 : sel + 1'b1;
    end
  end

  ////////////////////
  // response side
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= '0;
    end else begin
      rsp_valid <= res_valid ? (NR_OF_REQ'(1) << res_tag) : '0;
    end
  end

  always_ff @(posedge clk) begin
    rsp <= res;  // shared by all requesters
  end

endmodule

`default_nettype wire

// File: design/channel_strip.sv
////////////////////
// channel strip
// gain then pan on one input sample through the
// shared multiplier, gives left and right parts
////////////////////

`timescale 1ns/1ns
`default_nettype none

module channel_strip import mixer_pkg::*; (
  input  wire           clk,
  input  wire           rst_n,
  input  wire           start,
  input  wire  audio_t  sample,
  input  wire  audio_t  gain,
  input  wire  audio_t  pan,
  output logic          req_valid,
  output mul_req_t      req,
  input  wire           req_grant,
  input  wire           rsp_valid,
  input  wire mul_rsp_t rsp,
  output logic          done,
  output audio_t        left,
  output audio_t        right,
  output logic          clip
);

  strip_state_t state;

  audio_t sample_r;
  audio_t gain_r;
  audio_t pan_r;
  audio_t g_r;       // gained sample
  logic   g_ovf_r;

  logic signed [AUDIO_WIDTH:0] diff;  // g - p, one guard bit
  logic                        diff_sat;
  audio_t                      diff_clamped;

  assign diff     = {g_r[AUDIO_WIDTH-1], g_r} - {rsp.product[AUDIO_WIDTH-1], rsp.product};
  assign diff_sat = diff[AUDIO_WIDTH] ^ diff[AUDIO_WIDTH-1];

  always_comb begin
    if (!diff_sat) begin
      diff_clamped = diff[AUDIO_WIDTH-1:0];
    end else begin
      diff_clamped = diff[AUDIO_WIDTH] ? AUDIO_MIN : AUDIO_MAX;
    end
  end

  assign req_valid = (state == STRIP_GAIN_REQ) || (state == STRIP_PAN_REQ);
  assign done      = (state == STRIP_DONE);

  always_comb begin
    req.multiplicand = (state == STRIP_PAN_REQ) ? g_r   : sample_r;
    req.multiplier   = (state == STRIP_PAN_REQ) ? pan_r : gain_r;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= STRIP_IDLE;
      clip  <= 1'b0;
    end else begin
      case (state)
        STRIP_IDLE, STRIP_DONE: if (start) state <= STRIP_GAIN_REQ;
        STRIP_GAIN_REQ:  if (req_grant) state <= STRIP_GAIN_WAIT;
        STRIP_GAIN_WAIT: if (rsp_valid) state <= STRIP_PAN_REQ;
        STRIP_PAN_REQ:   if (req_grant) state <= STRIP_PAN_WAIT;
        STRIP_PAN_WAIT: begin
          if (rsp_valid) begin
            state <= STRIP_DONE;
            clip  <= g_ovf_r | diff_sat;
          end
        end
        default: state <= STRIP_IDLE;
      endcase
    end
  end

  // operands and results
  always_ff @(posedge clk) begin
    if (start && (state == STRIP_IDLE || state == STRIP_DONE)) begin
      sample_r <= sample;
      gain_r   <= gain;
      pan_r    <= pan;
    end
    if (rsp_valid && state == STRIP_GAIN_WAIT) begin
      g_r     <= rsp.product;
      g_ovf_r <= rsp.overflow;
    end
    if (rsp_valid && state == STRIP_PAN_WAIT) begin
      left  <= rsp.product;
      right <= diff_clamped;  // remainder goes right
    end
  end

endmodule

`default_nettype wire

// File: design/mix_bus.sv
////////////////////
// mix bus
// frame control, left/right bus sums, output
// gain through the shared multiplier, clip status
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mix_bus import mixer_pkg::*; #(
  parameter int NR_OF_CHANNELS = 4
) (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire                              channel_valid,
  output logic                             channel_ready,
  output logic                             start,
  input  wire  [NR_OF_CHANNELS-1:0]        strip_done,
  input  wire  audio_t [NR_OF_CHANNELS-1:0] strip_left,
  input  wire  audio_t [NR_OF_CHANNELS-1:0] strip_right,
  input  wire  [NR_OF_CHANNELS-1:0]        strip_clip,
  input  wire  audio_t                     output_gain,
  output logic                             req_valid,
  output mul_req_t                         req,
  input  wire                              req_grant,
  input  wire                              rsp_valid,
  input  wire  mul_rsp_t                   rsp,
  output audio_t                           out_left,
  output audio_t                           out_right,
  output logic                             out_valid,
  output logic [1:0]                       out_clip,
  output logic [NR_OF_CHANNELS-1:0]        channel_clip
);

  localparam int SUM_WIDTH = AUDIO_WIDTH + $clog2(NR_OF_CHANNELS + 1);

  typedef logic signed [SUM_WIDTH-1:0] sum_t;

  bus_state_t state;
  logic       accept;
  logic       side;        // 0 left, 1 right

  sum_t       left_sum;
  sum_t       right_sum;
  audio_t     out_gain_r;
  audio_t     left_sat_r;
  audio_t     right_sat_r;
  logic [1:0] sum_clip_r;
  logic [1:0] prod_ovf_r;
  audio_t     prod_left_r;
  audio_t     prod_right_r;

  function automatic audio_t clamp(input sum_t value);
    if (value > sum_t'(AUDIO_MAX)) return AUDIO_MAX;
    if (value < sum_t'(AUDIO_MIN)) return AUDIO_MIN;
    return value[AUDIO_WIDTH-1:0];
  endfunction

  function automatic logic clamped(input sum_t value);
    return (value > sum_t'(AUDIO_MAX)) || (value < sum_t'(AUDIO_MIN));
  endfunction

  assign accept = (state == BUS_IDLE) && channel_valid && channel_ready;

  always_comb begin
    left_sum  = '0;
    right_sum = '0;
    for (int i = 0; i < NR_OF_CHANNELS; i++) begin
      left_sum  = left_sum  + sum_t'($signed(strip_left[i]));
      right_sum = right_sum + sum_t'($signed(strip_right[i]));
    end
  end

  assign req_valid        = (state == BUS_OUT_REQ);
  assign req.multiplicand = side ? right_sat_r : left_sat_r;
  assign req.multiplier   = out_gain_r;

  ////////////////////
  // frame FSM
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= BUS_IDLE;
      channel_ready <= 1'b0;
      start         <= 1'b0;
      out_valid     <= 1'b0;
      side          <= 1'b0;
      out_clip      <= '0;
      channel_clip  <= '0;
    end else begin
      channel_ready <= (state == BUS_IDLE) && !accept;  // back one cycle after out_valid
      start         <= accept;
      out_valid     <= (state == BUS_EMIT);
      case (state)
        BUS_IDLE: if (accept) state <= BUS_WAIT_STRIPS;
        BUS_WAIT_STRIPS: begin
          // done is stale while start is still high
          if (&strip_done && !start) state <= BUS_SUM;
        end
        BUS_SUM: begin
          side  <= 1'b0;
          state <= BUS_OUT_REQ;
        end
        BUS_OUT_REQ: if (req_grant) state <= BUS_OUT_WAIT;
        BUS_OUT_WAIT: begin
          if (rsp_valid) begin
            side  <= 1'b1;
            state <= side ? BUS_EMIT : BUS_OUT_REQ;
          end
        end
        BUS_EMIT: begin
          out_clip     <= sum_clip_r | prod_ovf_r;
          channel_clip <= strip_clip;
          state        <= BUS_IDLE;
        end
        default: state <= BUS_IDLE;
      endcase
    end
  end

  // frame data
  always_ff @(posedge clk) begin
    if (accept) out_gain_r <= output_gain;
    if (state == BUS_SUM) begin
      left_sat_r  <= clamp(left_sum);
      right_sat_r <= clamp(right_sum);
      sum_clip_r  <= {clamped(right_sum), clamped(left_sum)};
    end
    if (state == BUS_OUT_WAIT && rsp_valid) begin
      if (side) begin
        prod_right_r  <= rsp.product;
        prod_ovf_r[1] <= rsp.overflow;
      end else begin
        prod_left_r   <= rsp.product;
        prod_ovf_r[0] <= rsp.overflow;
      end
    end
    if (state == BUS_EMIT) begin
      out_left  <= prod_left_r;
      out_right <= prod_right_r;
    end
  end

endmodule

`default_nettype wire

// File: design/mixer_core.sv
////////////////////
// audio mixer core
// channel strips and mix bus sharing one
// saturating multiplier through an arbiter
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mixer_core import mixer_pkg::*; #(
  parameter int NR_OF_CHANNELS = 4,
  parameter int Q_BITS         = 12
) (
  input  wire                               clk,
  input  wire                               rst_n,
  input  wire  audio_t [NR_OF_CHANNELS-1:0] channel_data,  // hold until start
  input  wire                               channel_valid,
  output logic                              channel_ready,
  input  wire  audio_t [NR_OF_CHANNELS-1:0] channel_gain,
  input  wire  audio_t [NR_OF_CHANNELS-1:0] channel_pan,
  input  wire  audio_t                      output_gain,
  output audio_t                            out_left,
  output audio_t                            out_right,
  output logic                              out_valid,
  output logic [1:0]                        out_clip,
  output logic [NR_OF_CHANNELS-1:0]         channel_clip
);

  localparam int ID_WIDTH = $clog2(NR_OF_CHANNELS + 1);

  // requesters 0..N-1 are strips, N is the mix bus
  logic     [NR_OF_CHANNELS:0] req_valid;
  mul_req_t [NR_OF_CHANNELS:0] req;
  logic     [NR_OF_CHANNELS:0] req_grant;
  logic     [NR_OF_CHANNELS:0] rsp_valid;
  mul_rsp_t                    rsp;

  logic                mul_valid;
  mul_req_t            mul_req;
  logic [ID_WIDTH-1:0] mul_tag;
  logic                res_valid;
  mul_rsp_t            res;
  logic [ID_WIDTH-1:0] res_tag;

  logic                                start;
  logic   [NR_OF_CHANNELS-1:0]         strip_done;
  audio_t [NR_OF_CHANNELS-1:0]         strip_left;
  audio_t [NR_OF_CHANNELS-1:0]         strip_right;
  logic   [NR_OF_CHANNELS-1:0]         strip_clip;

  for (genvar i = 0; i < NR_OF_CHANNELS; i++) begin : g_strip
    channel_strip channel_strip_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .sample    (channel_data[i]),
      .gain      (channel_gain[i]),
      .pan       (channel_pan[i]),
      .req_valid (req_valid[i]),
      .req       (req[i]),
      .req_grant (req_grant[i]),
      .rsp_valid (rsp_valid[i]),
      .rsp       (rsp),
      .done      (strip_done[i]),
      .left      (strip_left[i]),
      .right     (strip_right[i]),
      .clip      (strip_clip[i])
    );
  end

  mix_bus #(
    .NR_OF_CHANNELS (NR_OF_CHANNELS)
  ) mix_bus_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .channel_valid (channel_valid),
    .channel_ready (channel_ready),
    .start         (start),
    .strip_done    (strip_done),
    .strip_left    (strip_left),
    .strip_right   (strip_right),
    .strip_clip    (strip_clip),
    .output_gain   (output_gain),
    .req_valid     (req_valid[NR_OF_CHANNELS]),
    .req           (req[NR_OF_CHANNELS]),
    .req_grant     (req_grant[NR_OF_CHANNELS]),
    .rsp_valid     (rsp_valid[NR_OF_CHANNELS]),
    .rsp           (rsp),
    .out_left      (out_left),
    .out_right     (out_right),
    .out_valid     (out_valid),
    .out_clip      (out_clip),
    .channel_clip  (channel_clip)
  );

  mul_arbiter #(
    .NR_OF_CHANNELS (NR_OF_CHANNELS),
    .ID_WIDTH       (ID_WIDTH)
  ) mul_arbiter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req       (req),
    .req_grant (req_grant),
    .mul_valid (mul_valid),
    .mul_req   (mul_req),
    .mul_tag   (mul_tag),
    .res_valid (res_valid),
    .res       (res),
    .res_tag   (res_tag),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
  );

  nq_multiplier #(
    .Q_BITS   (Q_BITS),
    .ID_WIDTH (ID_WIDTH)
  ) nq_multiplier_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .mul_valid (mul_valid),
    .mul_req   (mul_req),
    .mul_tag   (mul_tag),
    .res_valid (res_valid),
    .res       (res),
    .res_tag   (res_tag)
  );

endmodule

`default_nettype wire

// File: tests/mixer_core_checker.sv
////////////////////
// mixer core checker
// handshake and arbitration properties,
// bound into the mixer core
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mixer_core_checker #(
  parameter int NR_OF_CHANNELS = 4,
  parameter int ID_WIDTH       = 3
) (
  input wire                    clk,
  input wire                    rst_n,
  input wire                    channel_valid,
  input wire                    channel_ready,
  input wire                    out_valid,
  input wire                    mul_valid,
  input wire [ID_WIDTH-1:0]     mul_tag,
  input wire [NR_OF_CHANNELS:0] req_valid,
  input wire [NR_OF_CHANNELS:0] req_grant
);

  int   failures = 0;
  logic in_frame;  // between acceptance and out_valid

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_frame <= 1'b0;
    end else if (channel_valid && channel_ready) begin
      in_frame <= 1'b1;
    end else if (out_valid) begin
      in_frame <= 1'b0;
    end
  end

  out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |=> !out_valid)
    else begin
      failures++;
      $error("out_valid held for more than one cycle");
    end

  // one job in flight per requester
  tag_repeat: assert property (@(posedge clk) disable iff (!rst_n)
    mul_valid |=> !(mul_valid && (mul_tag == $past(mul_tag))))
    else begin
      failures++;
      $error("same tag issued in consecutive cycles");
    end

  ready_busy: assert property (@(posedge clk) disable iff (!rst_n)
    in_frame |-> !channel_ready)
    else begin
      failures++;
      $error("channel_ready high while a frame is in progress");
    end

  // a single grant, and only to a pending requester
  one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(req_grant) && ((req_grant & ~req_valid) == '0))
    else begin
      failures++;
      $error("more than one grant in a cycle or a grant without a request");
    end

endmodule

bind mixer_core mixer_core_checker #(
  .NR_OF_CHANNELS (NR_OF_CHANNELS),
  .ID_WIDTH       (ID_WIDTH)
) mixer_core_checker_inst (
  .clk           (clk),
  .rst_n         (rst_n),
  .channel_valid (channel_valid),
  .channel_ready (channel_ready),
  .out_valid     (out_valid),
  .mul_valid     (mul_valid),
  .mul_tag       (mul_tag),
  .req_valid     (req_valid),
  .req_grant     (req_grant)
);

`default_nettype wire

// File: tests/mixer_core_tb.sv
////////////////////
// audio mixer testbench
// random and directed frames against a model of
// the gain, pan, bus sum and output gain rules
////////////////////

`timescale 1ns/1ns
`default_nettype none

module mixer_core_tb import mixer_pkg::*; ();

  localparam int NCH     = 4;
  localparam int Q_BITS  = 12;
  localparam int TIMEOUT = 200;  // cycles per wait

  typedef struct packed {
    logic [NCH-1:0] ch_clip;
    logic [1:0]     o_clip;
    audio_t         left;
    audio_t         right;
  } frame_result_t;

  logic                 clk;
  logic                 rst_n;
  audio_t [NCH-1:0]     channel_data;
  audio_t [NCH-1:0]     channel_gain;
  audio_t [NCH-1:0]     channel_pan;
  audio_t               output_gain;
  logic                 channel_valid;
  logic                 channel_ready;
  audio_t               out_left;
  audio_t               out_right;
  logic                 out_valid;
  logic [1:0]           out_clip;
  logic [NCH-1:0]       channel_clip;

  logic [31:0]          lfsr_state;
  int                   value_errors;
  int                   timeouts;
  int                   assertion_errors;
  frame_result_t        pending[$];  // accepted frames, oldest first

  mixer_core #(
    .NR_OF_CHANNELS (NCH),
    .Q_BITS         (Q_BITS)
  ) mixer_core_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .channel_data  (channel_data),
    .channel_valid (channel_valid),
    .channel_ready (channel_ready),
    .channel_gain  (channel_gain),
    .channel_pan   (channel_pan),
    .output_gain   (output_gain),
    .out_left      (out_left),
    .out_right     (out_right),
    .out_valid     (out_valid),
    .out_clip      (out_clip),
    .channel_clip  (channel_clip)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // random source
  ////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  ////////////////////
  // reference model
  ////////////////////

  function automatic longint clamp_audio(input longint v);
    if (v > 32767) return 32767;
    if (v < -32768) return -32768;
    return v;
  endfunction

  // unclamped Q product
  function automatic longint scale_q(input longint a, input longint b);
    return (a * b) >>> Q_BITS;
  endfunction

  function automatic frame_result_t expected_frame();
    frame_result_t e;
    longint g, gs, p, ps, d, ds;
    longint lsum, rsum, ls, rs, lo, ro;
    e    = '0;
    lsum = 0;
    rsum = 0;
    for (int i = 0; i < NCH; i++) begin
      g  = scale_q($signed(channel_data[i]), $signed(channel_gain[i]));
      gs = clamp_audio(g);
      p  = scale_q(gs, $signed(channel_pan[i]));
      ps = clamp_audio(p);
      d  = gs - ps;  // right gets the remainder
      ds = clamp_audio(d);
      e.ch_clip[i] = (g != gs) || (d != ds);
      lsum += ps;
      rsum += ds;
    end
    ls = clamp_audio(lsum);
    rs = clamp_audio(rsum);
    lo = scale_q(ls, $signed(output_gain));
    ro = scale_q(rs, $signed(output_gain));
    e.left      = audio_t'(clamp_audio(lo));
    e.right     = audio_t'(clamp_audio(ro));
    e.o_clip[0] = (ls != lsum) || (clamp_audio(lo) != lo);
    e.o_clip[1] = (rs != rsum) || (clamp_audio(ro) != ro);
    return e;
  endfunction

  ////////////////////
  // stimulus and checks
  ////////////////////

  task automatic randomize_frame();
    for (int i = 0; i < NCH; i++) begin
      channel_data[i] = audio_t'(random_bits(16));
      channel_gain[i] = audio_t'(random_bits(13));          // up to 2.0
      channel_pan[i]  = audio_t'(random_bits(13) % 4097);   // 0 .. 1.0
    end
    output_gain = audio_t'(random_bits(13));
  endtask

  task automatic compare_result(input frame_result_t e, input string what);
    if (out_left !== e.left) begin
      value_errors++;
      $display("error %0t ns: %s out_left %0d, expected %0d", $time, what, out_left, e.left);
    end
    if (out_right !== e.right) begin
      value_errors++;
      $display("error %0t ns: %s out_right %0d, expected %0d", $time, what, out_right, e.right);
    end
    if (out_clip !== e.o_clip) begin
      value_errors++;
      $display("error %0t ns: %s out_clip %b, expected %b", $time, what, out_clip, e.o_clip);
    end
    if (channel_clip !== e.ch_clip) begin
      value_errors++;
      $display("error %0t ns: %s channel_clip %b, expected %b",
               $time, what, channel_clip, e.ch_clip);
    end
  endtask

  task automatic wait_ready(output logic ok);
    int n;
    n = 0;
    while (!channel_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = channel_ready;
    if (!ok) begin
      timeouts++;
      $display("timeout at %0t ns: channel_ready did not come back", $time);
    end
  endtask

  task automatic wait_out(output logic ok);
    int n;
    n = 0;
    @(negedge clk);
    while (!out_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    ok = out_valid;
    if (!ok) begin
      timeouts++;
      $display("timeout at %0t ns: no out_valid after an accepted frame", $time);
    end
  endtask

  // one frame, returns on its out_valid
  task automatic run_frame(input string what);
    frame_result_t e;
    logic          ok;
    wait_ready(ok);
    if (ok) begin
      e = expected_frame();
      channel_valid = 1'b1;  // ready is high, so the next edge accepts
      @(negedge clk);
      channel_valid = 1'b0;
      wait_out(ok);
      if (ok) compare_result(e, what);
    end
  endtask

  // valid stays high across busy periods
  task automatic burst_frames(input int frames);
    int            sent;
    int            got;
    int            idle;
    frame_result_t e;
    sent = 0;
    got  = 0;
    idle = 0;
    randomize_frame();
    channel_valid = 1'b1;
    while (got < frames && idle < TIMEOUT) begin
      @(negedge clk);
      idle++;
      if (out_valid) begin
        idle = 0;
        got++;
        if (pending.size() == 0) begin
          value_errors++;
          $display("error %0t ns: out_valid without an accepted frame", $time);
        end else begin
          e = pending.pop_front();
          compare_result(e, "burst");
        end
        if (sent < frames) randomize_frame();
        else channel_valid = 1'b0;
      end
      if (channel_valid && channel_ready) begin
        pending.push_back(expected_frame());
        sent++;
      end
    end
    channel_valid = 1'b0;
    if (got < frames) begin
      timeouts++;
      $display("timeout at %0t ns: burst stalled after %0d frames", $time, got);
    end
    if (sent != frames) begin
      value_errors++;
      $display("error %0t ns: burst accepted %0d frames, expected %0d", $time, sent, frames);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        value_errors++;
        $display("error %0t ns: out_valid without a frame", $time);
      end
    end
  endtask

  ////////////////////
  // test sequence
  ////////////////////

  initial begin
    lfsr_state       = 32'd66760;
    value_errors     = 0;
    timeouts         = 0;
    assertion_errors = 0;
    rst_n            = 1'b0;
    channel_valid    = 1'b0;
    channel_data     = '0;
    channel_gain     = '0;
    channel_pan      = '0;
    output_gain      = '0;

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (channel_ready !== 1'b1) begin
      value_errors++;
      $display("error %0t ns: channel_ready low after reset", $time);
    end
    expect_quiet(10);

    repeat (20) begin
      randomize_frame();
      run_frame("random");
    end

    // gain 2.0 on large samples of channels 0 and 2
    channel_data[0] = audio_t'(20000);
    channel_data[1] = audio_t'(-300);
    channel_data[2] = audio_t'(-20000);
    channel_data[3] = audio_t'(500);
    for (int i = 0; i < NCH; i++) begin
      channel_gain[i] = (i % 2 == 0) ? audio_t'(8192) : audio_t'(4096);
      channel_pan[i]  = audio_t'(2048);
    end
    output_gain = audio_t'(4096);
    run_frame("gain clip");
    if (channel_clip !== 4'b0101) begin
      value_errors++;
      $display("error %0t ns: channel_clip %b, expected 0101", $time, channel_clip);
    end

    // loud, same sign, all left
    for (int i = 0; i < NCH; i++) begin
      channel_data[i] = audio_t'(30000);
      channel_gain[i] = audio_t'(4096);
      channel_pan[i]  = audio_t'(4096);
    end
    run_frame("loud");
    if (out_clip !== 2'b01 || out_left !== AUDIO_MAX) begin
      value_errors++;
      $display("error %0t ns: loud frame out_clip %b out_left %0d", $time, out_clip, out_left);
    end
    for (int i = 0; i < NCH; i++) channel_data[i] = audio_t'(100);
    run_frame("quiet");
    if (out_clip !== 2'b00) begin
      value_errors++;
      $display("error %0t ns: quiet frame out_clip %b, expected 00", $time, out_clip);
    end

    // pan extremes
    randomize_frame();
    for (int i = 0; i < NCH; i++) begin
      channel_gain[i] = audio_t'(4096);
      channel_pan[i]  = '0;
    end
    run_frame("pan right");
    if (out_left !== '0) begin
      value_errors++;
      $display("error %0t ns: pan 0 gave out_left %0d", $time, out_left);
    end
    for (int i = 0; i < NCH; i++) channel_pan[i] = audio_t'(4096);
    run_frame("pan left");
    if (out_right !== '0) begin
      value_errors++;
      $display("error %0t ns: pan 1.0 gave out_right %0d", $time, out_right);
    end

    burst_frames(6);
    expect_quiet(20);

    assertion_errors = mixer_core_inst.mixer_core_checker_inst.failures;
    $display("errors: %0d value, %0d timeout, %0d assertion",
             value_errors, timeouts, assertion_errors);
    if (value_errors + timeouts + assertion_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: audio_mixer.f
design/mixer_pkg.sv
design/nq_multiplier.sv
design/mul_arbiter.sv
design/channel_strip.sv
design/mix_bus.sv
design/mixer_core.sv
tests/mixer_core_checker.sv
tests/mixer_core_tb.sv

// File: Bender.yml
package:
  name: audio_mixer

sources:
  - design/mixer_pkg.sv
  - design/nq_multiplier.sv
  - design/mul_arbiter.sv
  - design/channel_strip.sv
  - design/mix_bus.sv
  - design/mixer_core.sv
  - target: test
    files:
      - tests/mixer_core_checker.sv
      - tests/mixer_core_tb.sv
